// File: src/csr_pkg.sv
/*
  Machine-mode CSR block definitions. Holds the CSR addresses, the
  access operation codes, the mstatus and mtvec layouts and the reset
  values shared by the trap registers and the performance monitor.
*/
package csr_pkg;

  localparam int unsigned XLEN  = 32;  // register width
  localparam int unsigned CNT_W = 64;  // performance counter width

  ////////////////////////////////////////////////////////////////////////////
  // addresses and operations
  ////////////////////////////////////////////////////////////////////////////

  // implemented csr addresses, anything else reads zero
  typedef enum logic [11:0] {
    CSR_MSTATUS       = 12'h300,
    CSR_MISA          = 12'h301,
    CSR_MIE           = 12'h304,
    CSR_MTVEC         = 12'h305,
    CSR_MCOUNTINHIBIT = 12'h320,
    CSR_MHPMEVENT3    = 12'h323,
    CSR_MSCRATCH      = 12'h340,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MIP           = 12'h344,
    CSR_MCYCLE        = 12'hB00,
    CSR_MINSTRET      = 12'hB02,
    CSR_MHPMCOUNTER3  = 12'hB03,
    CSR_MCYCLEH       = 12'hB80,  // upper halves
    CSR_MINSTRETH     = 12'hB82,
    CSR_MHPMCOUNTER3H = 12'hB83
  } csr_addr_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,  // no write
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  localparam logic [1:0] PRIV_M = 2'b11;  // machine mode

  ////////////////////////////////////////////////////////////////////////////
  // register layouts
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [18:0] zero3;  // 31:13
    logic [1:0]  mpp;    // 12:11
    logic [2:0]  zero2;  // 10:8
    logic        mpie;   // 7
    logic [2:0]  zero1;  // 6:4
    logic        mie;    // 3
    logic [2:0]  zero0;  // 2:0
  } mstatus_t;

  typedef struct packed {
    logic [23:0] addr;   // trap base, 256 byte aligned
    logic [5:0]  zero0;
    logic [1:0]  mode;   // 0 direct, 1 vectored
  } mtvec_t;

  // misa: C, I, M and MXL = 1 (rv32)
  localparam logic [XLEN-1:0] MISA_VALUE = (32'(1) <<  2)   // C
                                         | (32'(1) <<  8)   // I
                                         | (32'(1) << 12)   // M
                                         | (32'(1) << 30);  // MXL

  // writable mie/mip bits: msi, mti, mei and the platform irqs
  localparam logic [XLEN-1:0] IRQ_MASK = 32'hFFFF_0888;

  localparam mstatus_t MSTATUS_RST = '{
    zero3: '0, mpp: PRIV_M, zero2: '0, mpie: 1'b0, zero1: '0, mie: 1'b0, zero0: '0
  };

  localparam mtvec_t MTVEC_RST = '{addr: 24'h000100, zero0: '0, mode: 2'b01};

  // performance monitor events
  localparam int unsigned NUM_HPM_EVENTS = 4;
  localparam int unsigned HPM_EV_CYCLE   = 0;
  localparam int unsigned HPM_EV_LOAD    = 1;
  localparam int unsigned HPM_EV_STORE   = 2;
  localparam int unsigned HPM_EV_BRANCH  = 3;

  // counters start inhibited: mcycle, minstret, mhpmcounter3
  localparam logic [XLEN-1:0] INHIBIT_RST = 32'h0000_000D;

endpackage

// File: src/hpm_counter.sv
/*
  One 64-bit performance counter. Either half can be written from the
  CSR port; otherwise it adds one when enabled.
*/
module hpm_counter import csr_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wr_lo_i,    // write bits 31:0
  input  logic             wr_hi_i,    // write bits 63:32
  input  logic [XLEN-1:0]  wr_data_i,
  input  logic             inc_i,      // count this cycle
  output logic [CNT_W-1:0] count_o
);

  logic [CNT_W-1:0] count_q;

  // lower write > upper write > increment
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (wr_lo_i) begin
      count_q[XLEN-1:0] <= wr_data_i;
    end else if (wr_hi_i) begin
      count_q[CNT_W-1:XLEN] <= wr_data_i;
    end else if (inc_i) begin
      count_q <= count_q + CNT_W'(1);  // carries across halves
    end
  end

  assign count_o = count_q;

  // address decode upstream selects one half per access
  a_half_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(wr_lo_i && wr_hi_i)
  ) else $error("hpm_counter: both halves written in one cycle");

endmodule

// File: src/csr_access.sv
/*
  CSR access unit. Turns the operation on the register port into a
  write strobe and write value, and selects read data from the
  register block that claims the address.
*/
module csr_access import csr_pkg::*; (
  input  csr_op_e         csr_op_i,
  input  logic [XLEN-1:0] csr_wdata_i,
  input  logic            mtrap_hit_i,    // trap block owns the address
  input  logic [XLEN-1:0] mtrap_rdata_i,
  input  logic            hpm_hit_i,      // monitor owns the address
  input  logic [XLEN-1:0] hpm_rdata_i,
  output logic [XLEN-1:0] csr_rdata_o,
  output logic            wr_en_o,
  output logic [XLEN-1:0] wr_data_o
);

  // read select, unknown address reads zero
  always_comb begin
    if (mtrap_hit_i) begin
      csr_rdata_o = mtrap_rdata_i;
    end else if (hpm_hit_i) begin
      csr_rdata_o = hpm_rdata_i;
    end else begin
      csr_rdata_o = '0;
    end
  end

  // set/clear modify the value selected above
  always_comb begin
    wr_en_o   = 1'b1;
    wr_data_o = csr_wdata_i;
    case (csr_op_i)
      CSR_OP_WRITE: wr_data_o = csr_wdata_i;
      CSR_OP_SET:   wr_data_o = csr_rdata_o | csr_wdata_i;
      CSR_OP_CLEAR: wr_data_o = csr_rdata_o & ~csr_wdata_i;
      default:      wr_en_o   = 1'b0;  // plain read
    endcase
  end

  // address maps of the two register blocks must not overlap
  always_comb begin
    a_hit_excl: assert final (!(mtrap_hit_i && hpm_hit_i))
      else $error("csr_access: trap block and monitor both claim the address");
  end

endmodule

// File: src/csr_mtrap.sv
/*
  Machine trap registers. Holds mstatus, mie, mtvec, mscratch, mepc
  and mcause, legalizes software writes, and applies trap entry and
  MRET. misa and mip are read-only views.
*/
module csr_mtrap import csr_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  csr_addr_e       csr_addr_i,
  input  logic            wr_en_i,
  input  logic [XLEN-1:0] wr_data_i,
  input  logic [XLEN-1:0] mip_i,          // pending irqs from the platform
  input  logic            trap_save_i,    // trap entry
  input  logic [5:0]      trap_cause_i,   // bit 5 = interrupt
  input  logic [XLEN-1:0] trap_pc_i,
  input  logic            mret_i,
  output logic            hit_o,
  output logic [XLEN-1:0] rdata_o,
  output logic [23:0]     mtvec_addr_o,
  output logic [1:0]      mtvec_mode_o,
  output logic [XLEN-1:0] mepc_o,
  output logic            m_irq_enable_o
);

  mstatus_t        mstatus_q, mstatus_n;
  logic [XLEN-1:0] mie_q, mie_n;
  mtvec_t          mtvec_q, mtvec_n;
  logic [XLEN-1:0] mscratch_q, mscratch_n;
  logic [XLEN-1:0] mepc_q, mepc_n;
  logic [XLEN-1:0] mcause_q, mcause_n;
  mstatus_t        wr_status;  // write data in mstatus layout
  mtvec_t          wr_tvec;    // write data in mtvec layout

  assign wr_status = mstatus_t'(wr_data_i);
  assign wr_tvec   = mtvec_t'(wr_data_i);

  ////////////////////////////////////////////////////////////////////////////
  // read decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    hit_o   = 1'b1;
    rdata_o = '0;
    case (csr_addr_i)
      CSR_MSTATUS:  rdata_o = mstatus_q;
      CSR_MISA:     rdata_o = MISA_VALUE;  // constant
      CSR_MIE:      rdata_o = mie_q;
      CSR_MTVEC:    rdata_o = mtvec_q;
      CSR_MSCRATCH: rdata_o = mscratch_q;
      CSR_MEPC:     rdata_o = mepc_q;
      CSR_MCAUSE:   rdata_o = mcause_q;
      CSR_MIP:      rdata_o = mip_i & IRQ_MASK;  // live view
      default:      hit_o   = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // next state: software write, then mret, then trap on top
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_n  = mstatus_q;
    mie_n      = mie_q;
    mtvec_n    = mtvec_q;
    mscratch_n = mscratch_q;
    mepc_n     = mepc_q;
    mcause_n   = mcause_q;

    if (wr_en_i) begin
      case (csr_addr_i)
        CSR_MSTATUS: begin
          mstatus_n      = MSTATUS_RST;     // mpp stays machine
          mstatus_n.mie  = wr_status.mie;
          mstatus_n.mpie = wr_status.mpie;
        end
        CSR_MIE:      mie_n = wr_data_i & IRQ_MASK;
        CSR_MTVEC: begin
          mtvec_n.addr  = wr_tvec.addr;
          mtvec_n.zero0 = '0;
          mtvec_n.mode  = {1'b0, wr_tvec.mode[0]};  // direct or vectored only
        end
        CSR_MSCRATCH: mscratch_n = wr_data_i;
        CSR_MEPC:     mepc_n     = {wr_data_i[XLEN-1:1], 1'b0};  // halfword aligned
        CSR_MCAUSE:   mcause_n   = {wr_data_i[31], 26'd0, wr_data_i[4:0]};
        default: ;  // misa, mip are read only
      endcase
    end

    if (trap_save_i) begin
      // stack the irq enable and record where and why
      mstatus_n.mpie = mstatus_q.mie;
      mstatus_n.mie  = 1'b0;
      mepc_n         = {trap_pc_i[XLEN-1:1], 1'b0};
      mcause_n       = {trap_cause_i[5], 26'd0, trap_cause_i[4:0]};
    end else if (mret_i) begin
      mstatus_n.mie  = mstatus_q.mpie;  // unstack
      mstatus_n.mpie = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q  <= MSTATUS_RST;
      mie_q      <= '0;
      mtvec_q    <= MTVEC_RST;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else begin
      mstatus_q  <= mstatus_n;
      mie_q      <= mie_n;
      mtvec_q    <= mtvec_n;
      mscratch_q <= mscratch_n;
      mepc_q     <= mepc_n;
      mcause_q   <= mcause_n;
    end
  end

  assign mtvec_addr_o   = mtvec_q.addr;
  assign mtvec_mode_o   = mtvec_q.mode;
  assign mepc_o         = mepc_q;
  assign m_irq_enable_o = mstatus_q.mie;  // global machine irq enable

  // core controller never enters a trap and returns in the same cycle
  a_trap_mret_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(trap_save_i && mret_i)
  ) else $error("csr_mtrap: trap_save_i and mret_i high together");

endmodule

// File: src/csr_hpm.sv
/*
  Performance monitor. Decodes the counter, inhibit and event selector
  addresses, forms the count enables and muxes counter halves onto
  the read data. Counters are mcycle, minstret and mhpmcounter3.
*/
module csr_hpm import csr_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  csr_addr_e       csr_addr_i,
  input  logic            wr_en_i,
  input  logic [XLEN-1:0] wr_data_i,
  input  logic            instr_ret_i,  // instruction retired
  input  logic            ev_load_i,
  input  logic            ev_store_i,
  input  logic            ev_branch_i,
  output logic            hit_o,
  output logic [XLEN-1:0] rdata_o
);

  logic [NUM_HPM_EVENTS-1:0] events;
  logic [NUM_HPM_EVENTS-1:0] evt_sel_q;  // mhpmevent3, low bits only
  logic [2:0]                inhibit_q;  // {hpm3, minstret, mcycle}
  logic [2:0]                wr_lo;
  logic [2:0]                wr_hi;
  logic [2:0]                inc;
  logic [CNT_W-1:0]          cnt [3];

  assign events[HPM_EV_CYCLE]  = 1'b1;
  assign events[HPM_EV_LOAD]   = ev_load_i;
  assign events[HPM_EV_STORE]  = ev_store_i;
  assign events[HPM_EV_BRANCH] = ev_branch_i;

  // half-word write strobes, index 0 mcycle, 1 minstret, 2 hpm3
  assign wr_lo[0] = wr_en_i && (csr_addr_i == CSR_MCYCLE);
  assign wr_lo[1] = wr_en_i && (csr_addr_i == CSR_MINSTRET);
  assign wr_lo[2] = wr_en_i && (csr_addr_i == CSR_MHPMCOUNTER3);
  assign wr_hi[0] = wr_en_i && (csr_addr_i == CSR_MCYCLEH);
  assign wr_hi[1] = wr_en_i && (csr_addr_i == CSR_MINSTRETH);
  assign wr_hi[2] = wr_en_i && (csr_addr_i == CSR_MHPMCOUNTER3H);

  // count enables
  assign inc[0] = !inhibit_q[0];
  assign inc[1] = !inhibit_q[1] && instr_ret_i;
  assign inc[2] = !inhibit_q[2] && |(events & evt_sel_q);  // any selected event

  // control registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inhibit_q <= {INHIBIT_RST[3], INHIBIT_RST[2], INHIBIT_RST[0]};
      evt_sel_q <= '0;
    end else if (wr_en_i) begin
      if (csr_addr_i == CSR_MCOUNTINHIBIT) begin
        inhibit_q <= {wr_data_i[3], wr_data_i[2], wr_data_i[0]};  // bit 1 has no counter
      end
      if (csr_addr_i == CSR_MHPMEVENT3) begin
        evt_sel_q <= wr_data_i[NUM_HPM_EVENTS-1:0];
      end
    end
  end

  for (genvar i = 0; i < 3; i++) begin : gen_cnt
    hpm_counter u_cnt (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr_lo_i   (wr_lo[i]),
      .wr_hi_i   (wr_hi[i]),
      .wr_data_i (wr_data_i),
      .inc_i     (inc[i]),
      .count_o   (cnt[i])
    );
  end

  // read mux
  always_comb begin
    hit_o   = 1'b1;
    rdata_o = '0;
    case (csr_addr_i)
      CSR_MCYCLE:        rdata_o = cnt[0][XLEN-1:0];
      CSR_MINSTRET:      rdata_o = cnt[1][XLEN-1:0];
      CSR_MHPMCOUNTER3:  rdata_o = cnt[2][XLEN-1:0];
      CSR_MCYCLEH:       rdata_o = cnt[0][CNT_W-1:XLEN];
      CSR_MINSTRETH:     rdata_o = cnt[1][CNT_W-1:XLEN];
      CSR_MHPMCOUNTER3H: rdata_o = cnt[2][CNT_W-1:XLEN];
      CSR_MCOUNTINHIBIT: rdata_o = {{(XLEN-4){1'b0}}, inhibit_q[2:1], 1'b0, inhibit_q[0]};
      CSR_MHPMEVENT3:    rdata_o = {{(XLEN-NUM_HPM_EVENTS){1'b0}}, evt_sel_q};
      default:           hit_o   = 1'b0;
    endcase
  end

endmodule

// File: src/csr_top.sv
/*
  Machine-mode CSR block top level. Connects the access unit to the
  trap registers and the performance monitor.
*/
module csr_top import csr_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  // register port, single cycle
  input  csr_addr_e       csr_addr_i,
  input  csr_op_e         csr_op_i,
  input  logic [XLEN-1:0] csr_wdata_i,
  output logic [XLEN-1:0] csr_rdata_o,
  // interrupts and traps
  input  logic [XLEN-1:0] mip_i,
  input  logic            trap_save_i,
  input  logic [5:0]      trap_cause_i,
  input  logic [XLEN-1:0] trap_pc_i,
  input  logic            mret_i,
  // performance events
  input  logic            instr_ret_i,
  input  logic            ev_load_i,
  input  logic            ev_store_i,
  input  logic            ev_branch_i,
  // to the core
  output logic [23:0]     mtvec_addr_o,
  output logic [1:0]      mtvec_mode_o,
  output logic [XLEN-1:0] mepc_o,
  output logic            m_irq_enable_o
);

  logic            wr_en;
  logic [XLEN-1:0] wr_data;
  logic            mtrap_hit;
  logic [XLEN-1:0] mtrap_rdata;
  logic            hpm_hit;
  logic [XLEN-1:0] hpm_rdata;

  csr_access u_access (
    .csr_op_i      (csr_op_i),
    .csr_wdata_i   (csr_wdata_i),
    .mtrap_hit_i   (mtrap_hit),
    .mtrap_rdata_i (mtrap_rdata),
    .hpm_hit_i     (hpm_hit),
    .hpm_rdata_i   (hpm_rdata),
    .csr_rdata_o   (csr_rdata_o),
    .wr_en_o       (wr_en),
    .wr_data_o     (wr_data)
  );

  csr_mtrap u_mtrap (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_addr_i     (csr_addr_i),
    .wr_en_i        (wr_en),
    .wr_data_i      (wr_data),
    .mip_i          (mip_i),
    .trap_save_i    (trap_save_i),
    .trap_cause_i   (trap_cause_i),
    .trap_pc_i      (trap_pc_i),
    .mret_i         (mret_i),
    .hit_o          (mtrap_hit),
    .rdata_o        (mtrap_rdata),
    .mtvec_addr_o   (mtvec_addr_o),
    .mtvec_mode_o   (mtvec_mode_o),
    .mepc_o         (mepc_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  csr_hpm u_hpm (
    .clk         (clk),
    .rst_n       (rst_n),
    .csr_addr_i  (csr_addr_i),
    .wr_en_i     (wr_en),
    .wr_data_i   (wr_data),
    .instr_ret_i (instr_ret_i),
    .ev_load_i   (ev_load_i),
    .ev_store_i  (ev_store_i),
    .ev_branch_i (ev_branch_i),
    .hit_o       (hpm_hit),
    .rdata_o     (hpm_rdata)
  );

endmodule

// File: verif/csr_tb.sv
/*
  Directed testbench for the machine-mode CSR block. Drives the register
  port and the core event inputs, checks reset values, access operations,
  write legalization, trap entry and MRET, and the performance counters.
*/
module csr_tb import csr_pkg::*; ();

  localparam logic [31:0] SEED     = 32'hc4a66fe7;
  localparam int          POLL_MAX = 16;             // reads before giving up

  logic            clk;
  logic            rst_n;
  csr_addr_e       csr_addr;
  csr_op_e         csr_op;
  logic [31:0]     csr_wdata;
  logic [31:0]     csr_rdata;
  logic [31:0]     mip;
  logic            trap_save;
  logic [5:0]      trap_cause;
  logic [31:0]     trap_pc;
  logic            mret;
  logic            instr_ret;
  logic            ev_load;
  logic            ev_store;
  logic            ev_branch;
  logic [23:0]     mtvec_addr;
  logic [1:0]      mtvec_mode;
  logic [31:0]     mepc;
  logic            m_irq_enable;

  logic [31:0]     lfsr_q;
  int              checks;
  int              errors;
  int              tests;
  int              test_err0;    // error count when the current test began

  csr_top u_csr_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_addr_i     (csr_addr),
    .csr_op_i       (csr_op),
    .csr_wdata_i    (csr_wdata),
    .csr_rdata_o    (csr_rdata),
    .mip_i          (mip),
    .trap_save_i    (trap_save),
    .trap_cause_i   (trap_cause),
    .trap_pc_i      (trap_pc),
    .mret_i         (mret),
    .instr_ret_i    (instr_ret),
    .ev_load_i      (ev_load),
    .ev_store_i     (ev_store),
    .ev_branch_i    (ev_branch),
    .mtvec_addr_o   (mtvec_addr),
    .mtvec_mode_o   (mtvec_mode),
    .mepc_o         (mepc),
    .m_irq_enable_o (m_irq_enable)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // period 100
  end

  ////////////////////////////////////////////////////////////////////////////
  // random data and checking
  ////////////////////////////////////////////////////////////////////////////

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bit(output logic b);
    lfsr_q = lfsr_next(lfsr_q);
    b      = lfsr_q[0];
  endtask

  task automatic rand_word(output logic [31:0] w);
    logic b;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      rand_bit(b);
      w = {w[30:0], b};
    end
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    a_eq: assert (got === exp) else begin
      $display("Error: %s = 0x%h, expected 0x%h", what, got, exp);
      errors++;
    end
  endtask

  task automatic start_test();
    test_err0 = errors;
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == test_err0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - test_err0);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // register port access, each one cycle from falling edge to falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_access(input csr_op_e op, input csr_addr_e addr,
                              input logic [31:0] data, output logic [31:0] rdata);
    csr_op    = op;
    csr_addr  = addr;
    csr_wdata = data;
    #10;                   // read mux settles well before the edge
    rdata     = csr_rdata;
    @(negedge clk);
    csr_op    = CSR_OP_READ;  // idle again, no second write
  endtask

  task automatic csr_read(input csr_addr_e addr, output logic [31:0] rdata);
    drive_access(CSR_OP_READ, addr, 32'd0, rdata);
  endtask

  task automatic csr_write(input csr_addr_e addr, input logic [31:0] data);
    logic [31:0] rd;
    drive_access(CSR_OP_WRITE, addr, data, rd);
  endtask

  task automatic csr_set(input csr_addr_e addr, input logic [31:0] data);
    logic [31:0] rd;
    drive_access(CSR_OP_SET, addr, data, rd);
  endtask

  task automatic csr_clear(input csr_addr_e addr, input logic [31:0] data);
    logic [31:0] rd;
    drive_access(CSR_OP_CLEAR, addr, data, rd);
  endtask

  task automatic read_check(input csr_addr_e addr, input logic [31:0] exp, input string what);
    logic [31:0] rd;
    csr_read(addr, rd);
    check_eq(what, rd, exp);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    start_test();
    read_check(CSR_MSTATUS, 32'h0000_1800, "mstatus");   // mpp = machine
    read_check(CSR_MISA, 32'h4000_1104, "misa");         // mxl=1, m, i, c
    read_check(CSR_MIE, 32'd0, "mie");
    read_check(CSR_MTVEC, 32'h0001_0001, "mtvec");       // base 0x100, vectored
    read_check(CSR_MSCRATCH, 32'd0, "mscratch");
    read_check(CSR_MEPC, 32'd0, "mepc");
    read_check(CSR_MCAUSE, 32'd0, "mcause");
    read_check(CSR_MIP, 32'd0, "mip");
    read_check(CSR_MCYCLE, 32'd0, "mcycle");
    read_check(CSR_MCYCLEH, 32'd0, "mcycleh");
    read_check(CSR_MINSTRET, 32'd0, "minstret");
    read_check(CSR_MINSTRETH, 32'd0, "minstreth");
    read_check(CSR_MHPMCOUNTER3, 32'd0, "mhpmcounter3");
    read_check(CSR_MHPMCOUNTER3H, 32'd0, "mhpmcounter3h");
    read_check(CSR_MCOUNTINHIBIT, 32'h0000_000D, "mcountinhibit");  // all three held
    read_check(CSR_MHPMEVENT3, 32'd0, "mhpmevent3");
    read_check(csr_addr_e'(12'h7C0), 32'd0, "unimplemented csr");
    check_eq("m_irq_enable_o", {31'd0, m_irq_enable}, 32'd0);
    check_eq("mtvec_addr_o", {8'd0, mtvec_addr}, 32'h0000_0100);
    check_eq("mtvec_mode_o", {30'd0, mtvec_mode}, 32'd1);
    check_eq("mepc_o", mepc, 32'd0);
    finish_test("reset_values");
  endtask

  task automatic test_access();
    logic [31:0] d;
    logic [31:0] model;  // expected mscratch
    start_test();
    rand_word(d);
    csr_write(CSR_MSCRATCH, d);
    model = d;
    read_check(CSR_MSCRATCH, model, "mscratch after write");
    rand_word(d);
    csr_set(CSR_MSCRATCH, d);
    model = model | d;
    read_check(CSR_MSCRATCH, model, "mscratch after set");
    rand_word(d);
    csr_clear(CSR_MSCRATCH, d);
    model = model & ~d;
    read_check(CSR_MSCRATCH, model, "mscratch after clear");
    read_check(CSR_MSCRATCH, model, "mscratch after read");   // reads are side-effect free
    rand_word(d);
    csr_write(csr_addr_e'(12'h7C0), d);                        // nobody owns 0x7c0
    read_check(csr_addr_e'(12'h7C0), 32'd0, "unimplemented csr after write");
    read_check(CSR_MSCRATCH, model, "mscratch after stray write");
    read_check(CSR_MIE, 32'd0, "mie after stray write");
    finish_test("access_ops");
  endtask

  task automatic test_legalize();
    logic [31:0] w;
    start_test();
    csr_write(CSR_MIE, 32'hFFFF_FFFF);
    read_check(CSR_MIE, 32'hFFFF_0888, "mie all ones");  // bits 3, 7, 11, 31:16
    csr_write(CSR_MTVEC, 32'hFFFF_FFFF);
    read_check(CSR_MTVEC, 32'hFFFF_FF01, "mtvec all ones");
    check_eq("mtvec_addr_o", {8'd0, mtvec_addr}, 32'h00FF_FFFF);
    check_eq("mtvec_mode_o", {30'd0, mtvec_mode}, 32'd1);
    csr_write(CSR_MTVEC, 32'h0000_0200);                 // direct mode
    check_eq("mtvec_mode_o", {30'd0, mtvec_mode}, 32'd0);
    csr_write(CSR_MEPC, 32'hFFFF_FFFF);
    read_check(CSR_MEPC, 32'hFFFF_FFFE, "mepc all ones");
    check_eq("mepc_o", mepc, 32'hFFFF_FFFE);
    csr_write(CSR_MCAUSE, 32'hFFFF_FFFF);
    read_check(CSR_MCAUSE, 32'h8000_001F, "mcause all ones");
    rand_word(w);
    mip = w;
    read_check(CSR_MIP, w & 32'hFFFF_0888, "mip masked");
    mip = '0;
    csr_write(CSR_MSTATUS, 32'hFFFF_FFFF);
    read_check(CSR_MSTATUS, 32'h0000_1888, "mstatus all ones");  // mie, mpie, mpp
    csr_write(CSR_MSTATUS, 32'd0);
    read_check(CSR_MSTATUS, 32'h0000_1800, "mstatus zero");      // mpp sticks
    finish_test("legalization");
  endtask

  task automatic test_trap();
    logic [31:0] pc;
    start_test();
    csr_set(CSR_MSTATUS, 32'h0000_0008);                          // mie
    read_check(CSR_MSTATUS, 32'h0000_1808, "mstatus before trap");
    check_eq("m_irq_enable_o", {31'd0, m_irq_enable}, 32'd1);
    rand_word(pc);
    pc[0]      = 1'b1;    // odd pc, bit 0 must be dropped
    trap_save  = 1'b1;
    trap_cause = 6'h2B;   // interrupt, code 11
    trap_pc    = pc;
    @(negedge clk);
    trap_save  = 1'b0;
    check_eq("mepc_o", mepc, pc & 32'hFFFF_FFFE);
    read_check(CSR_MCAUSE, 32'h8000_000B, "mcause after trap");   // irq flag, code 11
    read_check(CSR_MSTATUS, 32'h0000_1880, "mstatus after trap");  // mpie = old mie
    check_eq("m_irq_enable_o", {31'd0, m_irq_enable}, 32'd0);
    mret = 1'b1;
    @(negedge clk);
    mret = 1'b0;
    read_check(CSR_MSTATUS, 32'h0000_1888, "mstatus after mret");
    check_eq("m_irq_enable_o", {31'd0, m_irq_enable}, 32'd1);
    // mret with mpie clear still sets it
    csr_write(CSR_MSTATUS, 32'd0);
    mret = 1'b1;
    @(negedge clk);
    mret = 1'b0;
    read_check(CSR_MSTATUS, 32'h0000_1880, "mstatus after second mret");
    check_eq("m_irq_enable_o", {31'd0, m_irq_enable}, 32'd0);
    finish_test("trap_mret");
  endtask

  task automatic test_counters();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] cnt;
    logic        b;
    int          tries;
    start_test();
    read_check(CSR_MCYCLE, 32'd0, "mcycle while inhibited");
    repeat (5) @(negedge clk);
    read_check(CSR_MCYCLE, 32'd0, "mcycle still inhibited");
    csr_write(CSR_MCOUNTINHIBIT, 32'd0);
    // wait for mcycle to start moving
    csr_read(CSR_MCYCLE, r0);
    r1    = r0;
    tries = 0;
    while (r1 == r0 && tries < POLL_MAX) begin
      csr_read(CSR_MCYCLE, r1);
      tries++;
    end
    checks++;
    a_moved: assert (r1 != r0) else begin
      $display("mcycle did not start counting within %0d reads", POLL_MAX);
      errors++;
    end
    csr_read(CSR_MCYCLE, r0);
    repeat (6) @(negedge clk);  // read cycle plus 6 idle = 7 edges
    csr_read(CSR_MCYCLE, r1);
    check_eq("mcycle delta over 7 cycles", r1 - r0, 32'd7);
    // minstret against random retire pulses
    cnt = '0;
    csr_read(CSR_MINSTRET, r0);
    for (int i = 0; i < 40; i++) begin
      rand_bit(b);
      instr_ret = b;
      cnt       = cnt + {31'd0, b};
      @(negedge clk);
    end
    instr_ret = 1'b0;
    csr_read(CSR_MINSTRET, r1);
    check_eq("minstret delta", r1 - r0, cnt);
    // carry from lower into upper half
    csr_write(CSR_MINSTRETH, 32'd0);
    csr_write(CSR_MINSTRET, 32'hFFFF_FFFF);
    instr_ret = 1'b1;
    @(negedge clk);
    instr_ret = 1'b0;
    read_check(CSR_MINSTRET, 32'd0, "minstret after carry");
    read_check(CSR_MINSTRETH, 32'd1, "minstreth after carry");
    finish_test("cycle_instret");
  endtask

  task automatic test_events();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] cnt;
    logic        ld;
    logic        st;
    logic        br;
    start_test();
    csr_write(CSR_MHPMEVENT3, 32'h0000_000A);  // load (bit 1) and branch (bit 3)
    read_check(CSR_MHPMEVENT3, 32'h0000_000A, "mhpmevent3");
    cnt = '0;
    csr_read(CSR_MHPMCOUNTER3, r0);
    for (int i = 0; i < 48; i++) begin
      rand_bit(ld);
      rand_bit(st);
      rand_bit(br);
      ev_load   = ld;
      ev_store  = st;   // not selected
      ev_branch = br;
      cnt       = cnt + {31'd0, ld | br};
      @(negedge clk);
    end
    ev_load   = 1'b0;
    ev_store  = 1'b0;
    ev_branch = 1'b0;
    csr_read(CSR_MHPMCOUNTER3, r1);
    check_eq("mhpmcounter3 delta", r1 - r0, cnt);
    read_check(CSR_MHPMCOUNTER3H, 32'd0, "mhpmcounter3h");
    finish_test("event_counter");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n      = 1'b0;
    csr_addr   = CSR_MSTATUS;
    csr_op     = CSR_OP_READ;
    csr_wdata  = '0;
    mip        = '0;
    trap_save  = 1'b0;
    trap_cause = '0;
    trap_pc    = '0;
    mret       = 1'b0;
    instr_ret  = 1'b0;
    ev_load    = 1'b0;
    ev_store   = 1'b0;
    ev_branch  = 1'b0;
    lfsr_q     = SEED;
    checks     = 0;
    errors     = 0;
    tests      = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;   // released away from the edge
    test_reset();
    test_access();
    test_legalize();
    test_trap();
    test_counters();
    test_events();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: verilog.f
src/csr_pkg.sv
src/hpm_counter.sv
src/csr_access.sv
src/csr_mtrap.sv
src/csr_hpm.sv
src/csr_top.sv
verif/csr_tb.sv

// File: run.sh
#!/bin/sh
# build and run the csr block testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module csr_tb -o csr_sim
out=$(./obj_dir/csr_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF -- '*** TEST PASSED ***'; then
  exit 0
fi
exit 1
